/* ls_pkg.sv */
package ls_pkg;

    // datapath and tag widths
    localparam int data_width = 32;
    localparam int tag_width  = 4;

    // tag 0 means the value is already present
    localparam logic [tag_width-1:0] tag_free = '0;

    // load/store buffer geometry
    localparam int buf_size = 4;
    localparam int buf_sel  = 2;

    // data memory geometry, word organised
    localparam int mem_words = 256;
    localparam int mem_sel   = 8;

    typedef enum logic [2:0] {
        op_nop = 3'd0,
        op_lw  = 3'd1,
        op_lb  = 3'd2,
        op_lbu = 3'd3,
        op_sw  = 3'd4,
        op_sb  = 3'd5
    } ls_op_e;

    // result broadcast, alu or memory
    typedef struct packed {
        logic                  en;
        logic [tag_width-1:0]  tag;
        logic [data_width-1:0] data;
    } cdb_t;

    // one operation as handed over by the decoder
    // stores carry dest == tag_free
    typedef struct packed {
        ls_op_e                op;
        logic [tag_width-1:0]  dest;
        logic [data_width-1:0] base;
        logic [tag_width-1:0]  base_tag;
        logic [data_width-1:0] src;
        logic [tag_width-1:0]  src_tag;
        logic [data_width-1:0] imm;
    } ls_alloc_t;

    // operation sent to the execution unit, operands resolved
    typedef struct packed {
        ls_op_e                op;
        logic [data_width-1:0] base;
        logic [data_width-1:0] imm;
        logic [data_width-1:0] src;
        logic [tag_width-1:0]  dest;
    } ls_issue_t;

    // word request to the data memory
    typedef struct packed {
        logic [mem_sel-1:0]    idx;
        logic [3:0]            we;
        logic [data_width-1:0] wdata;
    } mem_req_t;

endpackage

/* ls_buffer_entry.sv */
`timescale 1ns/1ps

module ls_buffer_entry (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              busy,
    input  logic              alloc_en,
    input  ls_pkg::ls_alloc_t alloc,
    input  ls_pkg::cdb_t      alu_cdb,
    input  ls_pkg::cdb_t      mem_cdb,
    output ls_pkg::ls_issue_t issue,
    output logic              complete
);

    ls_pkg::ls_op_e                    op;
    logic [ls_pkg::tag_width-1:0]      dest;
    logic [ls_pkg::data_width-1:0]     base;
    logic [ls_pkg::tag_width-1:0]      base_tag;
    logic [ls_pkg::data_width-1:0]     src;
    logic [ls_pkg::tag_width-1:0]      src_tag;
    logic [ls_pkg::data_width-1:0]     imm;

    logic                              base_alu_hit;
    logic                              base_mem_hit;
    logic                              src_alu_hit;
    logic                              src_mem_hit;
    logic [ls_pkg::data_width-1:0]     base_now;
    logic [ls_pkg::tag_width-1:0]      base_tag_now;
    logic [ls_pkg::data_width-1:0]     src_now;
    logic [ls_pkg::tag_width-1:0]      src_tag_now;

    function automatic logic tag_hit(input logic [ls_pkg::tag_width-1:0] tag,
                                     input ls_pkg::cdb_t cdb);
        return cdb.en && (tag != ls_pkg::tag_free) && (cdb.tag == tag);
    endfunction

    // snoop both buses, alu bus wins if both match
    always_comb begin
        base_alu_hit = tag_hit(base_tag, alu_cdb);
        base_mem_hit = tag_hit(base_tag, mem_cdb);
        src_alu_hit  = tag_hit(src_tag, alu_cdb);
        src_mem_hit  = tag_hit(src_tag, mem_cdb);

        base_now     = base_alu_hit ? alu_cdb.data : (base_mem_hit ? mem_cdb.data : base);
        base_tag_now = (base_alu_hit || base_mem_hit) ? ls_pkg::tag_free : base_tag;
        src_now      = src_alu_hit ? alu_cdb.data : (src_mem_hit ? mem_cdb.data : src);
        src_tag_now  = (src_alu_hit || src_mem_hit) ? ls_pkg::tag_free : src_tag;
    end

    assign issue.op   = op;
    assign issue.base = base_now;
    assign issue.imm  = imm;
    assign issue.src  = src_now;
    assign issue.dest = dest;

    assign complete = busy && (base_tag_now == ls_pkg::tag_free)
                      && (src_tag_now == ls_pkg::tag_free);

    // tags and op
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            op       <= ls_pkg::op_nop;
            dest     <= ls_pkg::tag_free;
            base_tag <= ls_pkg::tag_free;
            src_tag  <= ls_pkg::tag_free;
        end else if (rdy) begin
            if (alloc_en) begin
                op       <= alloc.op;
                dest     <= alloc.dest;
                base_tag <= alloc.base_tag;
                src_tag  <= alloc.src_tag;
            end else begin
                base_tag <= base_tag_now;
                src_tag  <= src_tag_now;
            end
        end
    end

    // operand payload
    always_ff @(posedge clk) begin
        if (rdy) begin
            if (alloc_en) begin
                base <= alloc.base;
                src  <= alloc.src;
                imm  <= alloc.imm;
            end else begin
                base <= base_now;
                src  <= src_now;
            end
        end
    end

endmodule

/* ls_buffer.sv */
`timescale 1ns/1ps

module ls_buffer (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              alloc_en,
    input  ls_pkg::ls_alloc_t alloc,
    input  ls_pkg::cdb_t      alu_cdb,
    input  ls_pkg::cdb_t      mem_cdb,
    input  logic              exec_idle,
    output logic              issue_en,
    output ls_pkg::ls_issue_t issue,
    output logic              buf_free
);

    logic [ls_pkg::buf_size-1:0]   busy;
    logic [ls_pkg::buf_size-1:0]   complete;
    logic [ls_pkg::buf_sel-1:0]    alloc_ptr;
    logic [ls_pkg::buf_sel-1:0]    issue_ptr;
    logic [ls_pkg::buf_sel:0]      count;
    ls_pkg::ls_issue_t             views [ls_pkg::buf_size];
    logic                          issue_go;

    // only the head entry may issue
    assign issue_go = complete[issue_ptr] && exec_idle;

    assign buf_free =
        !(((count == (ls_pkg::buf_sel + 1)'(ls_pkg::buf_size)) && !issue_go) ||
          ((count == (ls_pkg::buf_sel + 1)'(ls_pkg::buf_size - 1)) && alloc_en));

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy      <= '0;
            alloc_ptr <= '0;
            issue_ptr <= '0;
            count     <= '0;
        end else if (rdy) begin
            if (alloc_en && issue_go) begin
                // count unchanged
                // a full buffer refills the slot that issues
                busy[issue_ptr] <= 1'b0;
                busy[alloc_ptr] <= 1'b1;
                alloc_ptr       <= alloc_ptr + 1'b1;
                issue_ptr       <= issue_ptr + 1'b1;
            end else if (alloc_en) begin
                busy[alloc_ptr] <= 1'b1;
                alloc_ptr       <= alloc_ptr + 1'b1;
                count           <= count + 1'b1;
            end else if (issue_go) begin
                busy[issue_ptr] <= 1'b0;
                issue_ptr       <= issue_ptr + 1'b1;
                count           <= count - 1'b1;
            end
        end
    end

    for (genvar i = 0; i < ls_pkg::buf_size; i++) begin : g_entry
        ls_buffer_entry u_entry (
            .clk      (clk),
            .rst      (rst),
            .rdy      (rdy),
            .busy     (busy[i]),
            .alloc_en (alloc_en && (alloc_ptr == ls_pkg::buf_sel'(i))),
            .alloc    (alloc),
            .alu_cdb  (alu_cdb),
            .mem_cdb  (mem_cdb),
            .issue    (views[i]),
            .complete (complete[i])
        );
    end

    // issue port is zero when not issuing
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            issue_en <= 1'b0;
            issue    <= '0;
        end else if (rdy) begin
            issue_en <= issue_go;
            if (issue_go) begin
                issue <= views[issue_ptr];
            end else begin
                issue <= '0;
            end
        end
    end

endmodule

/* ls_exec.sv */
`timescale 1ns/1ps

module ls_exec (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          rdy,
    input  logic                          issue_en,
    input  ls_pkg::ls_issue_t             issue,
    output logic                          exec_idle,
    output ls_pkg::mem_req_t              mem_req,
    output logic                          mem_rd_en,
    input  logic [ls_pkg::data_width-1:0] rd_data,
    output ls_pkg::cdb_t                  mem_cdb
);

    typedef enum logic {
        st_idle,
        st_load_wb
    } state_e;

    state_e                          state;
    logic [ls_pkg::data_width-1:0]   addr;
    logic [1:0]                      lane;
    logic                            is_load;
    logic                            is_store;

    // held for the write back cycle
    ls_pkg::ls_op_e                  ld_op;
    logic [ls_pkg::tag_width-1:0]    ld_dest;
    logic [1:0]                      ld_lane;
    logic [7:0]                      ld_byte;

    assign addr     = issue.base + issue.imm;
    assign lane     = addr[1:0];
    assign is_load  = issue.op inside {ls_pkg::op_lw, ls_pkg::op_lb, ls_pkg::op_lbu};
    assign is_store = issue.op inside {ls_pkg::op_sw, ls_pkg::op_sb};

    assign exec_idle = (state == st_idle) && !issue_en;

    // memory request in the issue_en cycle
    always_comb begin
        mem_req.idx   = addr[ls_pkg::mem_sel+1:2];
        mem_req.we    = '0;
        mem_req.wdata = issue.src;
        mem_rd_en     = rdy && issue_en && is_load;
        if (rdy && issue_en && is_store) begin
            if (issue.op == ls_pkg::op_sb) begin
                mem_req.we    = 4'b0001 << lane;
                mem_req.wdata = {4{issue.src[7:0]}};
            end else begin
                // word store, low address bits ignored
                mem_req.we = 4'b1111;
            end
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state <= st_idle;
        end else if (rdy) begin
            case (state)
                st_idle: begin
                    if (issue_en && is_load) begin
                        state <= st_load_wb;
                    end
                end
                st_load_wb: state <= st_idle;
                default:    state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && issue_en && is_load) begin
            ld_op   <= issue.op;
            ld_dest <= issue.dest;
            ld_lane <= lane;
        end
    end

    assign ld_byte = rd_data[{ld_lane, 3'b000} +: 8];

    // load result broadcast
    always_comb begin
        mem_cdb.en  = (state == st_load_wb);
        mem_cdb.tag = ld_dest;
        case (ld_op)
            ls_pkg::op_lb:  mem_cdb.data = {{24{ld_byte[7]}}, ld_byte};
            ls_pkg::op_lbu: mem_cdb.data = {24'b0, ld_byte};
            default:        mem_cdb.data = rd_data;
        endcase
    end

endmodule

/* data_mem.sv */
`timescale 1ns/1ps

module data_mem (
    input  logic                          clk,
    input  ls_pkg::mem_req_t              mem_req,
    input  logic                          rd_en,
    output logic [ls_pkg::data_width-1:0] rd_data
);

    logic [ls_pkg::data_width-1:0] mem [ls_pkg::mem_words];

    // per byte lane writes
    always_ff @(posedge clk) begin
        for (int b = 0; b < 4; b++) begin
            if (mem_req.we[b]) begin
                mem[mem_req.idx][b*8 +: 8] <= mem_req.wdata[b*8 +: 8];
            end
        end
    end

    // registered read, old data on a same-cycle write
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_data <= mem[mem_req.idx];
        end
    end

endmodule

/* ls_top.sv */
`timescale 1ns/1ps

module ls_top (
    input  logic              clk,
    input  logic              rst,
    input  logic              rdy,
    input  logic              alloc_en,
    input  ls_pkg::ls_alloc_t alloc,
    input  ls_pkg::cdb_t      alu_cdb,
    output ls_pkg::cdb_t      mem_cdb,
    output logic              buf_free
);

    logic                          issue_en;
    ls_pkg::ls_issue_t             issue;
    logic                          exec_idle;
    ls_pkg::mem_req_t              mem_req;
    logic                          mem_rd_en;
    logic [ls_pkg::data_width-1:0] rd_data;

    ls_buffer u_buffer (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .alloc_en  (alloc_en),
        .alloc     (alloc),
        .alu_cdb   (alu_cdb),
        // load results wake up waiting entries
        .mem_cdb   (mem_cdb),
        .exec_idle (exec_idle),
        .issue_en  (issue_en),
        .issue     (issue),
        .buf_free  (buf_free)
    );

    ls_exec u_exec (
        .clk       (clk),
        .rst       (rst),
        .rdy       (rdy),
        .issue_en  (issue_en),
        .issue     (issue),
        .exec_idle (exec_idle),
        .mem_req   (mem_req),
        .mem_rd_en (mem_rd_en),
        .rd_data   (rd_data),
        .mem_cdb   (mem_cdb)
    );

    data_mem u_mem (
        .clk     (clk),
        .mem_req (mem_req),
        .rd_en   (mem_rd_en),
        .rd_data (rd_data)
    );

endmodule

/* tb_ls_top.sv */
`timescale 1ns/1ps

module tb_ls_top;

    localparam int clk_period = 40;
    localparam int num_tests  = 6;
    localparam int wait_limit = 100;

    logic              clk;
    logic              rst;
    logic              rdy;
    logic              alloc_en;
    ls_pkg::ls_alloc_t alloc;
    ls_pkg::cdb_t      alu_cdb;
    ls_pkg::cdb_t      mem_cdb;
    logic              buf_free;

    // byte image of everything the stores wrote
    logic [7:0] ref_mem [1024];

    logic [ls_pkg::tag_width-1:0]  got_tag [$];
    logic [ls_pkg::data_width-1:0] got_data [$];

    integer seed = 32'hbb3d;
    int     errors;
    int     failed_tests;
    int     test_errors;
    string  cur_test;

    ls_top u_dut (
        .clk      (clk),
        .rst      (rst),
        .rdy      (rdy),
        .alloc_en (alloc_en),
        .alloc    (alloc),
        .alu_cdb  (alu_cdb),
        .mem_cdb  (mem_cdb),
        .buf_free (buf_free)
    );

    always #(clk_period / 2) clk = ~clk;

    // every memory bus result, in arrival order
    always @(negedge clk) begin
        if (mem_cdb.en) begin
            got_tag.push_back(mem_cdb.tag);
            got_data.push_back(mem_cdb.data);
        end
    end

    initial begin
        #(num_tests * 200 * clk_period);
        $display("timeout, the tests did not finish in time");
        $display("Something failed");
        $finish;
    end

    function automatic ls_pkg::ls_alloc_t make_record(
        input ls_pkg::ls_op_e op, input logic [3:0] dest,
        input logic [31:0] base, input logic [3:0] base_tag,
        input logic [31:0] src, input logic [3:0] src_tag, input logic [31:0] imm);
        ls_pkg::ls_alloc_t rec;
        rec.op       = op;
        rec.dest     = dest;
        rec.base     = base;
        rec.base_tag = base_tag;
        rec.src      = src;
        rec.src_tag  = src_tag;
        rec.imm      = imm;
        return rec;
    endfunction

    // memory wraps at 1 KiB, word stores ignore the low address bits
    function automatic void model_store(input ls_pkg::ls_op_e op, input logic [31:0] addr,
                                        input logic [31:0] data);
        logic [9:0] a;
        a = addr[9:0];
        if (op == ls_pkg::op_sb) begin
            ref_mem[a] = data[7:0];
        end else begin
            for (int i = 0; i < 4; i++) begin
                ref_mem[{a[9:2], i[1:0]}] = data[i*8 +: 8];
            end
        end
    endfunction

    function automatic logic [31:0] model_load(input ls_pkg::ls_op_e op,
                                               input logic [31:0] addr);
        logic [9:0] a;
        logic [7:0] b;
        a = addr[9:0];
        b = ref_mem[a];
        case (op)
            ls_pkg::op_lb:  return {{24{b[7]}}, b};
            ls_pkg::op_lbu: return {24'h0, b};
            default: return {ref_mem[{a[9:2], 2'd3}], ref_mem[{a[9:2], 2'd2}],
                             ref_mem[{a[9:2], 2'd1}], ref_mem[{a[9:2], 2'd0}]};
        endcase
    endfunction

    task automatic value_error(input string what, input logic [31:0] exp,
                               input logic [31:0] act);
        $display("error %s: %s expected %h actual %h", cur_test, what, exp, act);
        errors++;
        test_errors++;
    endtask

    task automatic report_failure(input string msg);
        $display("failure in %s: %s", cur_test, msg);
        errors++;
        test_errors++;
    endtask

    task automatic start_test(input string name);
        cur_test    = name;
        test_errors = 0;
    endtask

    task automatic end_test();
        if (test_errors == 0) begin
            $display("test %s passed", cur_test);
        end else begin
            $display("test %s failed with %0d errors", cur_test, test_errors);
            failed_tests++;
        end
    endtask

    task automatic wait_cycles(input int n);
        repeat (n) @(posedge clk);
    endtask

    task automatic alloc_op(input ls_pkg::ls_alloc_t rec);
        @(negedge clk);
        if (!buf_free) begin
            report_failure("allocation attempted while the buffer was full");
        end
        @(posedge clk);
        alloc_en <= 1'b1;
        alloc    <= rec;
        @(posedge clk);
        alloc_en <= 1'b0;
    endtask

    task automatic send_alu(input logic [3:0] tag, input logic [31:0] data);
        @(posedge clk);
        alu_cdb <= {1'b1, tag, data};
        @(posedge clk);
        alu_cdb <= '0;
    endtask

    task automatic expect_result(input logic [3:0] tag, input logic [31:0] data);
        int waited;
        waited = 0;
        while (got_tag.size() == 0 && waited < wait_limit) begin
            @(negedge clk);
            waited++;
        end
        if (got_tag.size() == 0) begin
            report_failure("no result appeared on the memory bus");
        end else begin
            if (got_tag[0] !== tag) value_error("result tag", 32'(tag), 32'(got_tag[0]));
            if (got_data[0] !== data) value_error("result data", data, got_data[0]);
            void'(got_tag.pop_front());
            void'(got_data.pop_front());
        end
    endtask

    task automatic expect_none(input string when);
        if (got_tag.size() != 0) begin
            report_failure({"unexpected result on the memory bus ", when});
            got_tag.delete();
            got_data.delete();
        end
    endtask

    task automatic test_reset_word();
        logic [31:0] addr;
        logic [31:0] word;
        start_test("reset_word");
        if (mem_cdb.en !== 1'b0) value_error("mem_cdb.en after reset", 32'd0, 32'(mem_cdb.en));
        if (buf_free !== 1'b1) value_error("buf_free after reset", 32'd1, 32'(buf_free));
        addr = {22'h0, 8'($random(seed)), 2'b00};
        word = $random(seed);
        alloc_op(make_record(ls_pkg::op_sw, ls_pkg::tag_free, addr, ls_pkg::tag_free,
                             word, ls_pkg::tag_free, 32'd0));
        model_store(ls_pkg::op_sw, addr, word);
        // base and imm both matter for the address
        alloc_op(make_record(ls_pkg::op_lw, 4'd12, addr - 32'd8, ls_pkg::tag_free,
                             32'd0, ls_pkg::tag_free, 32'd8));
        expect_result(4'd12, model_load(ls_pkg::op_lw, addr));
        end_test();
    endtask

    task automatic test_byte_ops();
        logic [31:0] addr;
        logic [31:0] word;
        logic [31:0] bval;
        logic [1:0]  lane;
        logic [1:0]  other;
        start_test("byte_ops");
        addr  = {22'h0, 8'($random(seed)), 2'b00};
        word  = $random(seed);
        bval  = $random(seed);
        bval[7] = 1'b1;
        lane  = 2'($random(seed));
        other = lane + 2'd1;
        alloc_op(make_record(ls_pkg::op_sw, ls_pkg::tag_free, addr, ls_pkg::tag_free,
                             word, ls_pkg::tag_free, 32'd0));
        model_store(ls_pkg::op_sw, addr, word);
        alloc_op(make_record(ls_pkg::op_sb, ls_pkg::tag_free, addr, ls_pkg::tag_free,
                             bval, ls_pkg::tag_free, {30'h0, lane}));
        model_store(ls_pkg::op_sb, addr + {30'h0, lane}, bval);
        alloc_op(make_record(ls_pkg::op_lw, 4'd1, addr, ls_pkg::tag_free,
                             32'd0, ls_pkg::tag_free, 32'd0));
        alloc_op(make_record(ls_pkg::op_lb, 4'd2, addr, ls_pkg::tag_free,
                             32'd0, ls_pkg::tag_free, {30'h0, lane}));
        alloc_op(make_record(ls_pkg::op_lbu, 4'd3, addr, ls_pkg::tag_free,
                             32'd0, ls_pkg::tag_free, {30'h0, lane}));
        alloc_op(make_record(ls_pkg::op_lb, 4'd4, addr, ls_pkg::tag_free,
                             32'd0, ls_pkg::tag_free, {30'h0, other}));
        expect_result(4'd1, model_load(ls_pkg::op_lw, addr));
        expect_result(4'd2, model_load(ls_pkg::op_lb, addr + {30'h0, lane}));
        expect_result(4'd3, model_load(ls_pkg::op_lbu, addr + {30'h0, lane}));
        expect_result(4'd4, model_load(ls_pkg::op_lb, addr + {30'h0, other}));
        end_test();
    endtask

    task automatic test_alu_wakeup();
        logic [31:0] addr1;
        logic [31:0] addr2;
        logic [31:0] w1;
        logic [31:0] w2;
        start_test("alu_wakeup");
        addr1 = {22'h0, 8'($random(seed)), 2'b00};
        addr2 = {22'h0, 8'($random(seed)), 2'b00};
        w1    = $random(seed);
        w2    = $random(seed);
        alloc_op(make_record(ls_pkg::op_sw, ls_pkg::tag_free, addr1, ls_pkg::tag_free,
                             w1, ls_pkg::tag_free, 32'd0));
        model_store(ls_pkg::op_sw, addr1, w1);
        alloc_op(make_record(ls_pkg::op_lw, 4'd8, 32'd0, 4'd6,
                             32'd0, ls_pkg::tag_free, 32'd4));
        wait_cycles(10);
        expect_none("while the base tag was pending");
        send_alu(4'd6, addr1 - 32'd4);
        expect_result(4'd8, model_load(ls_pkg::op_lw, addr1));
        // store data arrives late
        alloc_op(make_record(ls_pkg::op_sw, ls_pkg::tag_free, addr2, ls_pkg::tag_free,
                             32'd0, 4'd7, 32'd0));
        alloc_op(make_record(ls_pkg::op_lw, 4'd9, addr2, ls_pkg::tag_free,
                             32'd0, ls_pkg::tag_free, 32'd0));
        wait_cycles(10);
        expect_none("while the store data tag was pending");
        model_store(ls_pkg::op_sw, addr2, w2);
        send_alu(4'd7, w2);
        expect_result(4'd9, model_load(ls_pkg::op_lw, addr2));
        end_test();
    endtask

    task automatic test_mem_chain();
        logic [31:0] addr_a;
        logic [31:0] ptr;
        logic [31:0] target;
        start_test("mem_chain");
        addr_a = {22'h0, 1'b0, 7'($random(seed)), 2'b00};
        ptr    = {22'h0, 2'b10, 6'($random(seed)), 2'b00};
        target = $random(seed);
        alloc_op(make_record(ls_pkg::op_sw, ls_pkg::tag_free, addr_a, ls_pkg::tag_free,
                             ptr, ls_pkg::tag_free, 32'd0));
        model_store(ls_pkg::op_sw, addr_a, ptr);
        alloc_op(make_record(ls_pkg::op_sw, ls_pkg::tag_free, ptr, ls_pkg::tag_free,
                             target, ls_pkg::tag_free, 32'd12));
        model_store(ls_pkg::op_sw, ptr + 32'd12, target);
        // load b waits on the dest tag of load a
        alloc_op(make_record(ls_pkg::op_lw, 4'd3, 32'd0, 4'd11,
                             32'd0, ls_pkg::tag_free, 32'd0));
        alloc_op(make_record(ls_pkg::op_lw, 4'd4, 32'd0, 4'd3,
                             32'd0, ls_pkg::tag_free, 32'd12));
        wait_cycles(5);
        expect_none("before the pointer address was broadcast");
        send_alu(4'd11, addr_a);
        expect_result(4'd3, model_load(ls_pkg::op_lw, addr_a));
        expect_result(4'd4, model_load(ls_pkg::op_lw, ptr + 32'd12));
        end_test();
    endtask

    task automatic test_capacity();
        logic [31:0] base;
        logic [31:0] word;
        start_test("capacity");
        base = {22'h0, 4'($random(seed)), 4'h0, 2'b00};
        for (int i = 0; i < 4; i++) begin
            word = $random(seed);
            alloc_op(make_record(ls_pkg::op_sw, ls_pkg::tag_free, base, ls_pkg::tag_free,
                                 word, ls_pkg::tag_free, 32'(i * 4)));
            model_store(ls_pkg::op_sw, base + 32'(i * 4), word);
        end
        wait_cycles(12);
        for (int i = 0; i < 4; i++) begin
            alloc_op(make_record(ls_pkg::op_lw, 4'(i + 1), 32'd0, 4'd9,
                                 32'd0, ls_pkg::tag_free, 32'(i * 4)));
        end
        @(negedge clk);
        if (buf_free !== 1'b0) value_error("buf_free with four entries", 32'd0, 32'(buf_free));
        expect_none("while all four loads waited");
        send_alu(4'd9, base);
        for (int i = 0; i < 4; i++) begin
            expect_result(4'(i + 1), model_load(ls_pkg::op_lw, base + 32'(i * 4)));
        end
        wait_cycles(3);
        @(negedge clk);
        if (buf_free !== 1'b1) value_error("buf_free after draining", 32'd1, 32'(buf_free));
        end_test();
    endtask

    task automatic test_stall();
        logic [31:0] addr;
        logic [31:0] w1;
        logic [31:0] w2;
        ls_pkg::ls_alloc_t second;
        start_test("stall");
        addr = {22'h0, 7'($random(seed)), 1'b0, 2'b00};
        w1   = $random(seed);
        w2   = $random(seed);
        alloc_op(make_record(ls_pkg::op_sw, ls_pkg::tag_free, addr, ls_pkg::tag_free,
                             w1, ls_pkg::tag_free, 32'd0));
        model_store(ls_pkg::op_sw, addr, w1);
        alloc_op(make_record(ls_pkg::op_sw, ls_pkg::tag_free, addr, ls_pkg::tag_free,
                             w2, ls_pkg::tag_free, 32'd4));
        model_store(ls_pkg::op_sw, addr + 32'd4, w2);
        wait_cycles(8);
        alloc_op(make_record(ls_pkg::op_lw, 4'd5, 32'd0, 4'd10,
                             32'd0, ls_pkg::tag_free, 32'd0));
        second = make_record(ls_pkg::op_lw, 4'd6, addr, ls_pkg::tag_free,
                             32'd0, ls_pkg::tag_free, 32'd4);
        wait_cycles(3);
        // broadcast and allocation both land while stalled
        @(posedge clk);
        rdy      <= 1'b0;
        alu_cdb  <= {1'b1, 4'd10, addr};
        alloc_en <= 1'b1;
        alloc    <= second;
        wait_cycles(4);
        alu_cdb  <= '0;
        alloc_en <= 1'b0;
        @(posedge clk);
        rdy <= 1'b1;
        expect_none("while rdy was low");
        wait_cycles(6);
        expect_none("after rdy returned, stalled broadcast must be lost");
        send_alu(4'd10, addr);
        alloc_op(second);
        expect_result(4'd5, model_load(ls_pkg::op_lw, addr));
        expect_result(4'd6, model_load(ls_pkg::op_lw, addr + 32'd4));
        end_test();
    endtask

    initial begin
        clk          = 1'b0;
        rst          = 1'b1;
        rdy          = 1'b1;
        alloc_en     = 1'b0;
        alloc        = '0;
        alu_cdb      = '0;
        errors       = 0;
        failed_tests = 0;
        cur_test     = "setup";
        repeat (5) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        test_reset_word();
        test_byte_ops();
        test_alu_wakeup();
        test_mem_chain();
        test_capacity();
        test_stall();
        wait_cycles(5);
        expect_none("after the last test");
        $display("tests %0d, failed tests %0d, errors %0d", num_tests, failed_tests, errors);
        if (errors == 0) begin
            $display("Everything OK");
        end else begin
            $display("Something failed");
        end
        $finish;
    end

endmodule

/* compile.f */
ls_pkg.sv
ls_buffer_entry.sv
ls_buffer.sv
ls_exec.sv
data_mem.sv
ls_top.sv
tb_ls_top.sv

/* run_sim.sh */
#!/bin/sh
# build with verilator, run, then decide from the log
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f compile.f --top-module tb_ls_top \
    -o sim_ls_top > sim.log 2>&1 \
    && ./obj_dir/sim_ls_top >> sim.log 2>&1 \
    || { echo "build or run failed, see sim.log"; exit 1; }
grep -qx "Everything OK" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed, see sim.log"; exit 1; }
